// File: Bender.yml
package:
  name: ahb_ram_slave

sources:
  - include_dirs:
      - .
    files:
      - ahb_ram_pkg.sv
      - ahb_ram_port_if.sv
      - ahb_ram_ctrl.sv
      - ahb_byte_ram.sv
      - ahb_ram_slave.sv
      - tb_ahb_ram_slave.sv

// File: ahb_byte_ram.sv
`timescale 1ns/1ps

`include "ahb_ram_settings.svh"

module ahb_byte_ram
#(
    parameter int ADDR_WIDTH = `RAM_ADDR_WIDTH
)
(
    input  logic                       HCLK,
    ahb_ram_port_if.mem                port,
    output logic [`AHB_DATA_WIDTH-1:0] HRDATA
);

    localparam int LANES      = `AHB_LANES;
    localparam int LANE_WIDTH = `AHB_DATA_WIDTH / LANES;
    localparam int DEPTH      = 2 ** ADDR_WIDTH;

    // Each word is kept as separate byte lanes so that a lane can be written
    // on its own.
    logic [LANES-1:0][LANE_WIDTH-1:0] mem [DEPTH];

    // The read register samples the array before this edge's write lands,
    // so a read of the word being written returns its old value.
    always_ff @(posedge HCLK)
    begin
        for (int i = 0; i < LANES; i++)
        begin
            if (port.byte_mask[i])
            begin
                mem[port.write_addr][i] <= port.write_data[i*LANE_WIDTH +: LANE_WIDTH];
            end
        end
        HRDATA <= mem[port.read_addr];
    end

    a_write_addr_known : assert property (
        @(posedge HCLK)
        (|port.byte_mask) |-> !$isunknown(port.write_addr)
    )
    else $error("Write to unknown address with byte mask %b", port.byte_mask);

endmodule

// File: ahb_ram_ctrl.sv
`timescale 1ns/1ps

`include "ahb_ram_settings.svh"

module ahb_ram_ctrl
    import ahb_ram_pkg::*;
#(
    parameter int ADDR_WIDTH = `RAM_ADDR_WIDTH
)
(
    input  logic                       HCLK,
    input  logic                       HRESETn,
    input  logic                       HSEL,
    input  logic [`AHB_ADDR_WIDTH-1:0] HADDR,
    input  htrans_e                    HTRANS,
    input  hsize_e                     HSIZE,
    input  logic                       HWRITE,
    input  logic [`AHB_DATA_WIDTH-1:0] HWDATA,
    input  logic                       HREADY,
    ahb_ram_port_if.ctrl               port
);

    localparam int LANES       = `AHB_LANES;
    localparam int OFFSET_BITS = $clog2(LANES);

    localparam logic [LANES-1:0] ALL_LANES = '1;
    localparam logic [LANES-1:0] LANE_ONE  = LANES'(1);
    localparam logic [LANES-1:0] HALF_LO   = ALL_LANES >> (LANES / 2);
    localparam logic [LANES-1:0] HALF_HI   = ALL_LANES << (LANES / 2);

    logic                              accept;
    logic                              hsel_q;
    htrans_e                           htrans_q;
    logic                              hwrite_q;
    hsize_e                            hsize_q;
    logic [ADDR_WIDTH+OFFSET_BITS-1:0] addr_q;
    logic                              write_active;
    logic                              store_en;
    logic [LANES-1:0]                  lane_mask;

    // An address phase is taken when this slave is selected, the bus is ready
    // and the master has a real transfer on the bus.
    assign accept = HSEL && HREADY && (HTRANS == NONSEQ || HTRANS == SEQ);

    // The address phase is sampled on every ready cycle.
    // While HREADY is low the previous phase is held, which keeps a pending
    // write waiting for the other slave to finish.
    always_ff @(posedge HCLK)
    begin
        if (!HRESETn)
        begin
            hsel_q   <= 1'b0;
            htrans_q <= IDLE;
            hwrite_q <= 1'b0;
            hsize_q  <= BYTE;
        end
        else if (HREADY)
        begin
            hsel_q   <= HSEL;
            htrans_q <= HTRANS;
            hwrite_q <= HWRITE;
            hsize_q  <= HSIZE;
        end
    end

    // The address only matters while the flags above say a write is pending.
    always_ff @(posedge HCLK)
    begin
        if (HREADY)
        begin
            addr_q <= HADDR[ADDR_WIDTH+OFFSET_BITS-1:0];
        end
    end

    assign write_active = hsel_q && hwrite_q && (htrans_q == NONSEQ || htrans_q == SEQ);

    // The data phase completes on the edge where HREADY is high.
    assign store_en = write_active && HREADY;

    always_comb
    begin
        lane_mask = '0;
        if (store_en)
        begin
            case (hsize_q)
                BYTE:    lane_mask = LANE_ONE << addr_q[OFFSET_BITS-1:0];
                HALF:    lane_mask = addr_q[OFFSET_BITS-1] ? HALF_HI : HALF_LO;
                WORD:    lane_mask = ALL_LANES;
                default: lane_mask = '0;
            endcase
        end
    end

    // Reads use the live address, so the word is in the RAM's read register
    // by the start of the data phase.
    assign port.read_addr  = HADDR[ADDR_WIDTH+OFFSET_BITS-1:OFFSET_BITS];
    assign port.write_addr = addr_q[ADDR_WIDTH+OFFSET_BITS-1:OFFSET_BITS];
    assign port.write_data = HWDATA;
    assign port.byte_mask  = lane_mask;

    a_legal_size : assert property (
        @(posedge HCLK) disable iff (!HRESETn)
        accept |-> HSIZE inside {BYTE, HALF, WORD}
    )
    else $error("Accepted transfer with unsupported HSIZE %0d", HSIZE);

    a_half_aligned : assert property (
        @(posedge HCLK) disable iff (!HRESETn)
        (accept && HSIZE == HALF) |-> (HADDR[0] == 1'b0)
    )
    else $error("Halfword transfer at unaligned address %h", HADDR);

    a_word_aligned : assert property (
        @(posedge HCLK) disable iff (!HRESETn)
        (accept && HSIZE == WORD) |-> (HADDR[OFFSET_BITS-1:0] == '0)
    )
    else $error("Word transfer at unaligned address %h", HADDR);

endmodule

// File: ahb_ram_pkg.sv
package ahb_ram_pkg;

    // Transfer type, driven on HTRANS.
    // Only NONSEQ and SEQ carry a transfer.
    typedef enum logic [1:0]
    {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_e;

    // Transfer size, driven on HSIZE.
    // The slave serves up to a full word, so any larger encoding is illegal.
    typedef enum logic [2:0]
    {
        BYTE = 3'b000,
        HALF = 3'b001,
        WORD = 3'b010
    } hsize_e;

endpackage

// File: ahb_ram_port_if.sv
`timescale 1ns/1ps

`include "ahb_ram_settings.svh"

// Read and write ports from the address-phase controller to the RAM.
interface ahb_ram_port_if
#(
    parameter int ADDR_WIDTH = `RAM_ADDR_WIDTH
);

    logic [ADDR_WIDTH-1:0]      read_addr;
    logic [ADDR_WIDTH-1:0]      write_addr;
    logic [`AHB_DATA_WIDTH-1:0] write_data;
    logic [`AHB_LANES-1:0]      byte_mask;

    modport ctrl
    (
        output read_addr,
        output write_addr,
        output write_data,
        output byte_mask
    );

    modport mem
    (
        input read_addr,
        input write_addr,
        input write_data,
        input byte_mask
    );

endinterface

// File: ahb_ram_settings.svh
`ifndef AHB_RAM_SETTINGS_SVH
`define AHB_RAM_SETTINGS_SVH

// Word address bits of the RAM.
// The default of 6 gives 64 words, or 256 bytes.
`define RAM_ADDR_WIDTH 6

// AHB-Lite address and data bus widths.
`define AHB_ADDR_WIDTH 32
`define AHB_DATA_WIDTH 32

// Byte lanes on the data bus.
// A lane is AHB_DATA_WIDTH / AHB_LANES bits wide.
`define AHB_LANES 4

`endif

// File: ahb_ram_slave.sv
`timescale 1ns/1ps

`include "ahb_ram_settings.svh"

// AHB-Lite RAM slave with zero wait states.
// HREADYOUT and HRESP are tied by the fabric, since the slave is always ready
// and always answers OKAY.
module ahb_ram_slave
    import ahb_ram_pkg::*;
(
    input  logic                       HCLK,
    input  logic                       HRESETn,
    input  logic                       HSEL,
    input  logic [`AHB_ADDR_WIDTH-1:0] HADDR,
    input  logic [1:0]                 HTRANS,
    input  logic [2:0]                 HSIZE,
    input  logic                       HWRITE,
    input  logic [`AHB_DATA_WIDTH-1:0] HWDATA,
    input  logic                       HREADY,
    output logic [`AHB_DATA_WIDTH-1:0] HRDATA
);

    ahb_ram_port_if
    #(
        .ADDR_WIDTH ( `RAM_ADDR_WIDTH )
    )
    ram_port_i ();

    ahb_ram_ctrl
    #(
        .ADDR_WIDTH ( `RAM_ADDR_WIDTH )
    )
    ctrl_i
    (
        .HCLK    ( HCLK             ),
        .HRESETn ( HRESETn          ),
        .HSEL    ( HSEL             ),
        .HADDR   ( HADDR            ),
        .HTRANS  ( htrans_e'(HTRANS) ),
        .HSIZE   ( hsize_e'(HSIZE)   ),
        .HWRITE  ( HWRITE           ),
        .HWDATA  ( HWDATA           ),
        .HREADY  ( HREADY           ),
        .port    ( ram_port_i.ctrl  )
    );

    ahb_byte_ram
    #(
        .ADDR_WIDTH ( `RAM_ADDR_WIDTH )
    )
    ram_i
    (
        .HCLK   ( HCLK           ),
        .port   ( ram_port_i.mem ),
        .HRDATA ( HRDATA         )
    );

endmodule

// File: filelist.f
+incdir+.
ahb_ram_pkg.sv
ahb_ram_port_if.sv
ahb_ram_ctrl.sv
ahb_byte_ram.sv
ahb_ram_slave.sv
tb_ahb_ram_slave.sv

// File: tb_ahb_ram_slave.sv
`timescale 1ns/1ps

`include "ahb_ram_settings.svh"

module tb_ahb_ram_slave
    import ahb_ram_pkg::*;
();

    localparam int CLK_PERIOD = 10;
    localparam int DEPTH      = 2 ** `RAM_ADDR_WIDTH;
    localparam int LANES      = `AHB_LANES;
    localparam int LANE_W     = `AHB_DATA_WIDTH / `AHB_LANES;

    logic                       HCLK;
    logic                       HRESETn;
    logic                       HSEL;
    logic [`AHB_ADDR_WIDTH-1:0] HADDR;
    logic [1:0]                 HTRANS;
    logic [2:0]                 HSIZE;
    logic                       HWRITE;
    logic [`AHB_DATA_WIDTH-1:0] HWDATA;
    logic                       HREADY;
    logic [`AHB_DATA_WIDTH-1:0] HRDATA;

    // One entry per address phase. HWDATA and the expected read word are filled
    // in by the reference model before the table is applied.
    string                      name_q[$];
    logic                       sel_q[$];
    logic [1:0]                 trans_q[$];
    logic                       write_q[$];
    logic [2:0]                 size_q[$];
    logic [`AHB_ADDR_WIDTH-1:0] addr_q[$];
    logic [`AHB_DATA_WIDTH-1:0] wdata_q[$];
    bit                         chk_q[$];
    bit                         ready_q[$];
    logic [`AHB_DATA_WIDTH-1:0] hwdata_q[$];
    logic [`AHB_DATA_WIDTH-1:0] exp_q[$];

    logic [`AHB_DATA_WIDTH-1:0] model_mem [DEPTH];
    integer                     seed;
    int                         pass_count = 0;
    int                         fail_count = 0;
    bit                         table_ready = 1'b0;

    ahb_ram_slave dut_i
    (
        .HCLK    ( HCLK    ),
        .HRESETn ( HRESETn ),
        .HSEL    ( HSEL    ),
        .HADDR   ( HADDR   ),
        .HTRANS  ( HTRANS  ),
        .HSIZE   ( HSIZE   ),
        .HWRITE  ( HWRITE  ),
        .HWDATA  ( HWDATA  ),
        .HREADY  ( HREADY  ),
        .HRDATA  ( HRDATA  )
    );

    initial HCLK = 1'b0;
    always #(CLK_PERIOD / 2) HCLK = ~HCLK;

    function automatic int word_of(input logic [`AHB_ADDR_WIDTH-1:0] addr);
        return (addr >> 2) % DEPTH;
    endfunction

    // Lanes touched by a transfer of the given size at the given byte offset.
    function automatic logic [LANES-1:0] lanes_for(input logic [2:0] size,
                                                   input logic [1:0] offset);
        case (size)
            BYTE:    return 4'b0001 << offset;
            HALF:    return offset[1] ? 4'b1100 : 4'b0011;
            WORD:    return 4'b1111;
            default: return 4'b0000;
        endcase
    endfunction

    task automatic add_step(input string name, input logic sel, input logic [1:0] trans,
                            input logic write, input logic [2:0] size,
                            input logic [31:0] addr, input logic [31:0] data,
                            input bit chk, input bit ready);
        name_q.push_back(name);
        sel_q.push_back(sel);
        trans_q.push_back(trans);
        write_q.push_back(write);
        size_q.push_back(size);
        addr_q.push_back(addr);
        wdata_q.push_back(data);
        chk_q.push_back(chk);
        ready_q.push_back(ready);
    endtask

    task automatic add_write(input string name, input logic [2:0] size,
                             input logic [31:0] addr, input logic [31:0] data);
        add_step(name, 1'b1, NONSEQ, 1'b1, size, addr, data, 1'b0, 1'b1);
    endtask

    task automatic add_read(input string name, input logic [31:0] addr);
        add_step(name, 1'b1, NONSEQ, 1'b0, WORD, addr, 32'h0, 1'b1, 1'b1);
    endtask

    task automatic add_idle(input string name);
        add_step(name, 1'b0, IDLE, 1'b0, WORD, 32'h0, 32'h0, 1'b0, 1'b1);
    endtask

    task automatic build_table();
        logic [31:0] fill;
        seed = 32'h3749_fa10;
        add_write("word_wr_0", WORD, 32'h00, 32'h1111_0000);
        add_write("word_wr_1", WORD, 32'h04, 32'h2222_1111);
        add_write("word_wr_2", WORD, 32'h10, 32'hdead_beef);
        add_write("word_wr_3", WORD, 32'h28, 32'h2828_2828);
        add_write("word_wr_4", WORD, 32'hfc, 32'hcafe_f00d);
        add_read("word_rd_0", 32'h00);
        add_read("word_rd_1", 32'h04);
        add_read("word_rd_2", 32'h10);
        add_read("word_rd_4", 32'hfc);
        add_write("b2b_wr", WORD, 32'h20, 32'h0bad_cafe);
        add_read("b2b_rd_other", 32'h10);
        add_read("b2b_rd", 32'h20);
        add_write("byte_base_wr", WORD, 32'h40, 32'h8877_6655);
        for (int lane = 0; lane < LANES; lane++)
        begin
            add_write($sformatf("byte_lane%0d_wr", lane), BYTE, 32'h40 + lane,
                      32'h5a5a_5a5a ^ (32'hf0 << (lane * 8)));
            add_idle("byte_gap");
            add_read($sformatf("byte_lane%0d_rd", lane), 32'h40);
        end
        add_write("half_base_wr", WORD, 32'h48, 32'h1234_5678);
        add_write("half_lo_wr", HALF, 32'h48, 32'hffff_abcd);
        add_idle("half_gap");
        add_read("half_lo_rd", 32'h48);
        add_write("half_hi_wr", HALF, 32'h4a, 32'h9876_ffff);
        add_idle("half_gap");
        add_read("half_hi_rd", 32'h48);
        // None of these phases may reach the memory.
        add_step("nosel_wr", 1'b0, NONSEQ, 1'b1, WORD, 32'h04, 32'hbad0_0001, 1'b0, 1'b1);
        add_step("idle_wr", 1'b1, IDLE, 1'b1, WORD, 32'h04, 32'hbad0_0002, 1'b0, 1'b1);
        add_step("busy_wr", 1'b1, BUSY, 1'b1, WORD, 32'h04, 32'hbad0_0003, 1'b0, 1'b1);
        add_step("rd_xfer", 1'b1, NONSEQ, 1'b0, WORD, 32'h04, 32'hbad0_0004, 1'b0, 1'b1);
        add_idle("nowrite_gap");
        add_read("nowrite_rd", 32'h04);
        add_write("rdw_wr", WORD, 32'h10, 32'h0123_4567);
        add_read("rdw_rd_old", 32'h10);
        add_read("rdw_rd_new", 32'h10);
        // The write to 0x20 stays pending while HREADY is low, so the read taken
        // on the release edge still sees the old word.
        add_write("stall_wr", WORD, 32'h20, 32'h5555_aaaa);
        add_step("stall_hold_0", 1'b1, NONSEQ, 1'b1, WORD, 32'h28, 32'h7777_7777, 1'b0, 1'b0);
        add_step("stall_hold_1", 1'b1, NONSEQ, 1'b1, WORD, 32'h28, 32'h7777_7777, 1'b0, 1'b0);
        add_read("stall_release_rd", 32'h20);
        add_idle("stall_gap");
        add_read("stall_wr_rd", 32'h20);
        add_read("stall_skip_rd", 32'h28);
        for (int w = 0; w < DEPTH; w++)
        begin
            fill = $random(seed);
            add_write($sformatf("fill_wr_%0d", w), WORD, w * 4, fill);
        end
        for (int w = 0; w < DEPTH; w++)
        begin
            add_read($sformatf("fill_rd_%0d", w), w * 4);
        end
        add_idle("final_gap");
    endtask

    // Walks the table as the bus would see it. The read word is taken before
    // the write that completes on the same edge.
    task automatic compute_expected();
        logic                       pend_write;
        logic [2:0]                 pend_size;
        logic [`AHB_ADDR_WIDTH-1:0] pend_addr;
        logic [`AHB_DATA_WIDTH-1:0] bus_data;
        logic [LANES-1:0]           mask;
        pend_write = 1'b0;
        pend_size  = WORD;
        pend_addr  = '0;
        bus_data   = '0;
        for (int i = 0; i < name_q.size(); i++)
        begin
            hwdata_q.push_back(bus_data);
            exp_q.push_back(model_mem[word_of(addr_q[i])]);
            if (ready_q[i])
            begin
                if (pend_write)
                begin
                    mask = lanes_for(pend_size, pend_addr[1:0]);
                    for (int l = 0; l < LANES; l++)
                    begin
                        if (mask[l])
                        begin
                            model_mem[word_of(pend_addr)][l*LANE_W +: LANE_W] =
                                bus_data[l*LANE_W +: LANE_W];
                        end
                    end
                end
                pend_write = sel_q[i] && write_q[i] && (trans_q[i] == NONSEQ ||
                                                        trans_q[i] == SEQ);
                pend_size  = size_q[i];
                pend_addr  = addr_q[i];
                bus_data   = wdata_q[i];
            end
        end
    endtask

    task automatic drive_step(input int i);
        HSEL   = sel_q[i];
        HTRANS = trans_q[i];
        HWRITE = write_q[i];
        HSIZE  = size_q[i];
        HADDR  = addr_q[i];
        HWDATA = hwdata_q[i];
        HREADY = ready_q[i];
    endtask

    task automatic drive_idle();
        HSEL   = 1'b0;
        HTRANS = IDLE;
        HWRITE = 1'b0;
        HREADY = 1'b1;
    endtask

    task automatic check_read(input int i);
        assert (HRDATA === exp_q[i])
        begin
            pass_count++;
            $display("Pass %s: read %h", name_q[i], HRDATA);
        end
        else
        begin
            fail_count++;
            $display("Fail %s: expected %h, actual %h", name_q[i], exp_q[i], HRDATA);
        end
    endtask

    initial
    begin
        HRESETn = 1'b0;
        HSEL    = 1'b0;
        HADDR   = '0;
        HTRANS  = IDLE;
        HSIZE   = WORD;
        HWRITE  = 1'b0;
        HWDATA  = '0;
        HREADY  = 1'b1;
        build_table();
        compute_expected();
        table_ready = 1'b1;
        repeat (4) @(negedge HCLK);
        HRESETn = 1'b1;
        // HRDATA from the previous edge is sampled before the next phase is driven.
        for (int i = 0; i <= name_q.size(); i++)
        begin
            @(negedge HCLK);
            if (i > 0 && chk_q[i-1])
            begin
                check_read(i - 1);
            end
            if (i < name_q.size())
            begin
                drive_step(i);
            end
            else
            begin
                drive_idle();
            end
        end
        $display("Checks passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0)
        begin
            $display("Verification passed");
        end
        else
        begin
            $display("Verification failed");
        end
        $finish;
    end

    initial
    begin
        wait (table_ready);
        #((name_q.size() + 20) * CLK_PERIOD);
        $display("Timeout: the transfer table did not complete in the expected time");
        $display("Verification failed");
        $finish;
    end

endmodule
